/* common/l2t_cfg.svh */
`ifndef L2T_CFG_SVH
`define L2T_CFG_SVH

//////////////////////////////////////////////////
// Tag array geometry
//////////////////////////////////////////////////

`define L2T_SETS	64	// Sets per way
`define L2T_INDEX_W	6	// log2 of L2T_SETS
`define L2T_WAYS	4	// Two sub-banks of two ways

// Stored tag width
// Bit 0 holds the ECC bit, bits 27:1 take part in the compare
`define L2T_TAG_W	28

//////////////////////////////////////////////////
// Fuse redundancy registers
//////////////////////////////////////////////////

`define L2T_RED_VAL_W	7	// Column repair value, row uses 6 of it
`define L2T_RED_EN_W	2	// Repair enable bits

`endif

/* common/l2t_pkg.sv */
`default_nettype none

`include "l2t_cfg.svh"

// Types of the tag path
package l2t_pkg;

	// Set index of one request
	typedef logic [`L2T_INDEX_W-1:0] index_t;

	// One bit per way, one-hot on writes
	typedef logic [`L2T_WAYS-1:0] way_oh_t;

	// Stored tag, ECC bit in bit 0
	typedef logic [`L2T_TAG_W-1:0] tag_t;

	// Lookup tag, same as tag_t minus the ECC bit
	typedef logic [`L2T_TAG_W-2:0] lkup_t;

	// All ways of one set, way 0 in the low word
	typedef tag_t [`L2T_WAYS-1:0] tag_vec_t;

endpackage

`default_nettype wire

/* common/l2t_red_pkg.sv */
`default_nettype none

`include "l2t_cfg.svh"

// Types of the fuse redundancy bank
package l2t_red_pkg;

	localparam int RED_BANKS = 4;	// rid[3:2], even/odd alternate sub-banks
	localparam int RED_PER_BANK = 4;	// rid[1:0], 0 and 1 are row regs
	localparam int RED_ROW_W = `L2T_RED_VAL_W - 1;	// Row value width

	// Register id, bank in 3:2 and register in 1:0
	typedef logic [3:0] red_rid_t;

	typedef logic [`L2T_RED_VAL_W-1:0] red_val_t;	// Repair value
	typedef logic [`L2T_RED_EN_W-1:0] red_en_t;	// Repair enable

	// Row register view
	typedef struct packed {
		logic pad;	// Always written as zero
		logic [RED_ROW_W-1:0] val;
		red_en_t en;
	} red_row_t;

	// Column register view
	typedef struct packed {
		red_val_t val;
		red_en_t en;
	} red_col_t;

	// One stored register word, decoded by register number
	typedef union packed {
		red_row_t row;
		red_col_t col;
	} red_word_u;

endpackage

`default_nettype wire

/* common/l2t_req_if.sv */
`timescale 1ns/10ps
`default_nettype none

// Registered request, request stage to tag array
interface l2t_req_if;
	import l2t_pkg::*;

	index_t index_q;	// Set of the request
	way_oh_t way_q;	// Way to write
	logic wren_q;	// Write strobe
	logic rden_q;	// Read strobe
	tag_t wdata_q;	// Tag to store

	// Request stage side
	modport stage (
		output index_q,
		output way_q,
		output wren_q,
		output rden_q,
		output wdata_q
	);

	// Array side
	modport array (
		input index_q,
		input way_q,
		input wren_q,
		input rden_q,
		input wdata_q
	);

endinterface

`default_nettype wire

/* hw/l2t_req_stage.sv */
`timescale 1ns/10ps
`default_nettype none

// Request register in front of the tag array
// One request per cycle, every strobe taken
module l2t_req_stage (
	input wire logic rclk,
	input wire logic arst_l,
	input l2t_pkg::index_t index,	// Set index
	input l2t_pkg::way_oh_t way,	// One-hot write way
	input wire logic rd_en,	// Read strobe
	input wire logic wr_en,	// Write strobe
	input l2t_pkg::tag_t wrdata,	// Write tag with ECC bit
	l2t_req_if.stage req
);

	//////////////////////////////////////////////////
	// Strobes
	//////////////////////////////////////////////////

	// Cleared on reset so no stray access after it
	always_ff @(posedge rclk) begin
		if (!arst_l) begin
			req.wren_q <= 1'b0;
			req.rden_q <= 1'b0;
		end else begin
			req.wren_q <= wr_en;	// Write lands in array next edge
			req.rden_q <= rd_en;	// Read data out next cycle
		end
	end

	//////////////////////////////////////////////////
	// Payload
	//////////////////////////////////////////////////

	// Loaded every cycle, only meaningful with a strobe
	always_ff @(posedge rclk) begin
		req.index_q <= index;
		req.way_q <= way;
		req.wdata_q <= wrdata;	// True polarity, no inverted copy
	end

endmodule

`default_nettype wire

/* l2t_array/l2t_tag_array.sv */
`timescale 1ns/10ps
`default_nettype none

`include "l2t_cfg.svh"

// Tag storage, sets by ways
// Ways 0,1 form sub-bank 0 and ways 2,3 sub-bank 1
module l2t_tag_array (
	input wire logic rclk,
	l2t_req_if.array req,	// Registered request
	output l2t_pkg::tag_vec_t rd_tags,	// All ways of the read set
	output logic rden_q	// Read in progress
);
	import l2t_pkg::*;

	// Storage cells, no reset
	tag_t mem [`L2T_SETS][`L2T_WAYS];

	//////////////////////////////////////////////////
	// Write
	//////////////////////////////////////////////////

	// Rising edge after the request edge
	// Only the way flagged in way_q is touched
	always_ff @(posedge rclk) begin
		if (req.wren_q) begin
			for (int w = 0; w < `L2T_WAYS; w++) begin
				if (req.way_q[w]) begin
					mem[req.index_q][w] <= req.wdata_q;
				end
			end
		end
	end

	//////////////////////////////////////////////////
	// Read
	//////////////////////////////////////////////////

	// Combinational out of the registered set
	// Write and idle cycles give all zero, like precharged sense amps
	always_comb begin
		for (int w = 0; w < `L2T_WAYS; w++) begin
			if (req.rden_q) begin
				rd_tags[w] = mem[req.index_q][w];
			end else begin
				rd_tags[w] = '0;
			end
		end
	end

	assign rden_q = req.rden_q;	// Qualifies the compare downstream

endmodule

`default_nettype wire

/* hw/l2t_way_cmp.sv */
`timescale 1ns/10ps
`default_nettype none

`include "l2t_cfg.svh"

// Way compare and output register
module l2t_way_cmp (
	input wire logic rclk,
	input wire logic arst_l,
	input l2t_pkg::tag_vec_t rd_tags,	// From the array, zero unless read
	input wire logic rden_q,	// Read in progress
	input l2t_pkg::lkup_t lkup_tag,	// Arrives one cycle after rd_en
	output l2t_pkg::tag_vec_t tag_way,	// Registered read tags
	output l2t_pkg::way_oh_t way_sel	// Registered hit per way
);
	import l2t_pkg::*;

	way_oh_t hit;	// Unregistered hit vector

	//////////////////////////////////////////////////
	// Compare
	//////////////////////////////////////////////////

	// ECC bit left out of the match
	always_comb begin
		for (int w = 0; w < `L2T_WAYS; w++) begin
			hit[w] = rden_q && (rd_tags[w][`L2T_TAG_W-1:1] == lkup_tag);
		end
	end

	//////////////////////////////////////////////////
	// Output register
	//////////////////////////////////////////////////

	// Non-read cycles load zero tags and zero hits
	always_ff @(posedge rclk) begin
		if (!arst_l) begin
			tag_way <= '0;
			way_sel <= '0;
		end else begin
			tag_way <= rd_tags;
			way_sel <= hit;
		end
	end

endmodule

`default_nettype wire

/* hw/l2t_red_regs.sv */
`timescale 1ns/10ps
`default_nettype none

// Fuse redundancy registers
// 4 banks of 4, banks 0,2 serve sub-bank 0 and banks 1,3 sub-bank 1
module l2t_red_regs (
	input wire logic rclk,
	input wire logic arst_l,
	input wire logic fuse_wren,	// Qualified write strobe
	input l2t_red_pkg::red_rid_t fuse_rid,	// Register id for write and readback
	input l2t_red_pkg::red_val_t fuse_repair_value,
	input l2t_red_pkg::red_en_t fuse_repair_en,
	output l2t_red_pkg::red_val_t repair_value,	// Readback value
	output l2t_red_pkg::red_en_t repair_en	// Readback enable
);
	import l2t_red_pkg::*;

	red_word_u regs [RED_BANKS][RED_PER_BANK];	// Register words
	logic [RED_BANKS-1:0] bank_dec;	// One-hot bank
	logic [RED_PER_BANK-1:0] reg_dec;	// One-hot register in bank
	logic is_row;	// Registers 0,1 are row repair
	red_word_u wr_word;	// Word to store
	red_word_u rd_word;	// Word addressed by fuse_rid

	//////////////////////////////////////////////////
	// Id decode
	//////////////////////////////////////////////////

	always_comb begin
		bank_dec = '0;
		bank_dec[fuse_rid[3:2]] = 1'b1;
		reg_dec = '0;
		reg_dec[fuse_rid[1:0]] = 1'b1;
	end

	assign is_row = ~fuse_rid[1];

	// Row view drops value bit 6, pad kept at zero
	always_comb begin
		wr_word = '0;
		if (is_row) begin
			wr_word.row.val = fuse_repair_value[RED_ROW_W-1:0];
			wr_word.row.en = fuse_repair_en;
		end else begin
			wr_word.col.val = fuse_repair_value;
			wr_word.col.en = fuse_repair_en;
		end
	end

	//////////////////////////////////////////////////
	// Register write
	//////////////////////////////////////////////////

	always_ff @(posedge rclk) begin
		if (!arst_l) begin
			for (int b = 0; b < RED_BANKS; b++) begin
				for (int r = 0; r < RED_PER_BANK; r++) begin
					regs[b][r] <= '0;
				end
			end
		end else if (fuse_wren) begin
			for (int b = 0; b < RED_BANKS; b++) begin
				for (int r = 0; r < RED_PER_BANK; r++) begin
					if (bank_dec[b] && reg_dec[r]) begin
						regs[b][r] <= wr_word;	// Only the addressed one
					end
				end
			end
		end
	end

	//////////////////////////////////////////////////
	// Readback mux
	//////////////////////////////////////////////////

	assign rd_word = regs[fuse_rid[3:2]][fuse_rid[1:0]];

	// Combinational from fuse_rid
	always_comb begin
		repair_en = rd_word.col.en;	// Same low bits in both views
		if (is_row) begin
			repair_value = {1'b0, rd_word.row.val};	// Bit 6 reads zero
		end else begin
			repair_value = rd_word.col.val;
		end
	end

endmodule

`default_nettype wire

/* hw/l2t_top.sv */
`timescale 1ns/10ps
`default_nettype none

// L2 tag array top, one lookup port plus fuse redundancy bank
module l2t_top (
	input wire logic rclk,
	input wire logic arst_l,	// Sync, active low

	// Lookup port
	input l2t_pkg::index_t index,	// Set index
	input l2t_pkg::way_oh_t way,	// Fill way, one-hot
	input wire logic rd_en,	// Read strobe
	input wire logic wr_en,	// Write strobe, never with rd_en
	input l2t_pkg::tag_t wrdata,	// Tag with ECC bit
	input l2t_pkg::lkup_t lkup_tag,	// One cycle after rd_en
	output l2t_pkg::tag_vec_t tag_way,	// Read tags, all ways
	output l2t_pkg::way_oh_t way_sel,	// Hit per way

	// Fuse port
	input wire logic fuse_wren,
	input l2t_red_pkg::red_rid_t fuse_rid,
	input l2t_red_pkg::red_val_t fuse_repair_value,
	input l2t_red_pkg::red_en_t fuse_repair_en,
	output l2t_red_pkg::red_val_t repair_value,
	output l2t_red_pkg::red_en_t repair_en
);
	import l2t_pkg::*;

	tag_vec_t rd_tags;	// Array out, combinational
	logic rden_q;	// Registered read strobe

	l2t_req_if req_if ();	// Registered request

	//////////////////////////////////////////////////
	// Tag path
	//////////////////////////////////////////////////

	// Producer
	l2t_req_stage req_stage0 (
		.rclk	(rclk),
		.arst_l	(arst_l),
		.index	(index),
		.way	(way),
		.rd_en	(rd_en),
		.wr_en	(wr_en),
		.wrdata	(wrdata),
		.req	(req_if.stage)
	);

	// Storage
	l2t_tag_array tag_array0 (
		.rclk	(rclk),
		.req	(req_if.array),
		.rd_tags	(rd_tags),
		.rden_q	(rden_q)
	);

	// Consumer
	l2t_way_cmp way_cmp0 (
		.rclk	(rclk),
		.arst_l	(arst_l),
		.rd_tags	(rd_tags),
		.rden_q	(rden_q),
		.lkup_tag	(lkup_tag),
		.tag_way	(tag_way),
		.way_sel	(way_sel)
	);

	//////////////////////////////////////////////////
	// Redundancy, independent of the tag path
	//////////////////////////////////////////////////

	l2t_red_regs red_regs0 (
		.rclk	(rclk),
		.arst_l	(arst_l),
		.fuse_wren	(fuse_wren),
		.fuse_rid	(fuse_rid),
		.fuse_repair_value	(fuse_repair_value),
		.fuse_repair_en	(fuse_repair_en),
		.repair_value	(repair_value),
		.repair_en	(repair_en)
	);

endmodule

`default_nettype wire

/* verif/l2t_chk.sv */
`timescale 1ns/10ps
`default_nettype none

// Request rules on the lookup port, bound into l2t_top
module l2t_chk (
	input wire logic rclk,
	input wire logic arst_l,
	input wire logic rd_en,
	input wire logic wr_en,
	input l2t_pkg::way_oh_t way
);
	import l2t_pkg::*;

	//////////////////////////////////////////////////
	// Strobe rules
	//////////////////////////////////////////////////

	// One port, so never read and write together
	a_no_rd_wr: assert property (@(posedge rclk) disable iff (!arst_l)
		!(rd_en && wr_en))
		else $error("rd_en and wr_en high in the same cycle");

	// Write touches exactly one way
	a_way_onehot: assert property (@(posedge rclk) disable iff (!arst_l)
		wr_en |-> $onehot(way))
		else $error("Write with a way vector that is not one-hot");

endmodule

`default_nettype wire

/* verif/l2t_tb.sv */
`timescale 1ns/10ps
`default_nettype none

`include "l2t_cfg.svh"

// Testbench for l2t_top, seeded random traffic against a reference model
module l2t_tb;
	import l2t_pkg::*;
	import l2t_red_pkg::*;

	localparam int N_FILL = `L2T_SETS * `L2T_WAYS;	// Initial fill writes
	localparam int N_RAND = 600;	// Random tag cycles
	localparam int N_FUSE = 48;	// Three passes over 16 ids
	localparam int MAX_CYCLES = 2 + N_FILL + N_RAND + 2 + 2 * N_FUSE + 50;

	logic rclk;
	logic arst_l;
	index_t index;
	way_oh_t way;
	logic rd_en;
	logic wr_en;
	tag_t wrdata;
	lkup_t lkup_tag;
	tag_vec_t tag_way;
	way_oh_t way_sel;
	logic fuse_wren;
	red_rid_t fuse_rid;
	red_val_t fuse_repair_value;
	red_en_t fuse_repair_en;
	red_val_t repair_value;
	red_en_t repair_en;

	integer seed;	// $random state
	int cycles = 0;	// Timeout counter
	tag_t mem_model [`L2T_SETS][`L2T_WAYS];	// Expected array contents
	red_word_u red_model [16];	// Expected readback per id
	logic p1_rd;	// Read driven last cycle
	tag_vec_t p1_tags;	// Model tags of that read

	l2t_top dut0 (.*);

	bind l2t_top l2t_chk chk0 (
		.rclk	(rclk),
		.arst_l	(arst_l),
		.rd_en	(rd_en),
		.wr_en	(wr_en),
		.way	(way)
	);

	always #2 rclk = ~rclk;	// 4 ns period

	// Hard stop, length of all phases plus margin
	always @(posedge rclk) begin
		cycles <= cycles + 1;
		if (cycles >= MAX_CYCLES) begin
			$display("Timeout after %0d cycles, run did not finish", cycles);
			$display("CHECKS FAILED");
			$fatal(1, "Cycle limit reached");
		end
	end

	//////////////////////////////////////////////////
	// Compare tasks
	//////////////////////////////////////////////////

	task automatic check_tags(input string name, input tag_vec_t exp, input tag_vec_t act);
		if (act !== exp) begin
			$display("CHECK FAILED %s: expected %h, actual %h", name, exp, act);
			$display("CHECKS FAILED");
			$fatal(1, "Tag mismatch in %s", name);
		end
	endtask

	task automatic check_sel(input string name, input way_oh_t exp, input way_oh_t act);
		if (act !== exp) begin
			$display("CHECK FAILED %s: expected %h, actual %h", name, exp, act);
			$display("CHECKS FAILED");
			$fatal(1, "Way select mismatch in %s", name);
		end
	endtask

	task automatic check_red(input string name, input red_word_u exp, input red_word_u act);
		if (act !== exp) begin
			$display("CHECK FAILED %s: expected %h, actual %h", name, exp, act);
			$display("CHECKS FAILED");
			$fatal(1, "Repair readback mismatch in %s", name);
		end
	endtask

	//////////////////////////////////////////////////
	// Stimulus helpers
	//////////////////////////////////////////////////

	task automatic next_cycle();
		@(posedge rclk);
		#1;	// Drive point, outputs settled
	endtask

	// Repair outputs seen through the column view
	function automatic red_word_u readback_word();
		red_word_u w;
		w.col.val = repair_value;
		w.col.en = repair_en;
		return w;
	endfunction

	// One lookup-port cycle, then check the edge it ends on
	task automatic tag_cycle(input logic do_rd, input logic do_wr, input index_t idx,
			input way_oh_t w, input tag_t d);
		lkup_t lk;
		way_oh_t exp_sel;
		tag_vec_t exp_tags;
		logic [31:0] r;
		lk = $random(seed);
		exp_sel = '0;
		exp_tags = '0;	// Idle or write cycle gives zero
		if (p1_rd) begin
			r = $random(seed);
			if (r[2]) begin
				lk = p1_tags[r[1:0]][`L2T_TAG_W-1:1];	// Aim at a stored way
			end
			for (int i = 0; i < `L2T_WAYS; i++) begin
				exp_sel[i] = (p1_tags[i][`L2T_TAG_W-1:1] == lk);	// ECC bit ignored
			end
			exp_tags = p1_tags;
		end
		rd_en = do_rd;
		wr_en = do_wr;
		index = idx;
		way = w;
		wrdata = d;
		lkup_tag = lk;	// Belongs to last cycle's read
		p1_rd = do_rd;
		p1_tags = '0;
		if (do_rd) begin
			for (int i = 0; i < `L2T_WAYS; i++) begin
				p1_tags[i] = mem_model[idx][i];
			end
		end
		if (do_wr) begin
			for (int i = 0; i < `L2T_WAYS; i++) begin
				if (w[i]) mem_model[idx][i] = d;	// Visible to the next read
			end
		end
		next_cycle();
		check_tags("tag_way", exp_tags, tag_way);
		check_sel("way_sel", exp_sel, way_sel);
	endtask

	// Fuse write, then readback of a random id
	task automatic fuse_cycle(input red_rid_t wid);
		red_val_t v;
		red_en_t e;
		red_rid_t rid;
		red_word_u w;
		v = $random(seed);
		e = $random(seed);
		fuse_wren = 1'b1;
		fuse_rid = wid;
		fuse_repair_value = v;
		fuse_repair_en = e;
		w.col.val = (wid[1:0] < 2) ? {1'b0, v[5:0]} : v;	// Row regs lose bit 6
		w.col.en = e;
		red_model[wid] = w;
		next_cycle();
		rid = $random(seed);
		fuse_wren = 1'b0;
		fuse_rid = rid;
		#1;	// Combinational readback
		check_red("fuse readback", red_model[rid], readback_word());
		next_cycle();
	endtask

	//////////////////////////////////////////////////
	// Test sequence
	//////////////////////////////////////////////////

	initial begin
		logic [31:0] r;
		seed = 55;
		rclk = 1'b0;
		arst_l = 1'b0;
		index = '0;
		way = '0;
		rd_en = 1'b0;
		wr_en = 1'b0;
		wrdata = '0;
		lkup_tag = '0;
		fuse_wren = 1'b0;
		fuse_rid = '0;
		fuse_repair_value = '0;
		fuse_repair_en = '0;
		p1_rd = 1'b0;
		p1_tags = '0;
		for (int i = 0; i < 16; i++) red_model[i] = '0;
		repeat (2) @(posedge rclk);	// Two reset edges
		#1;
		arst_l = 1'b1;
		check_tags("reset tag_way", '0, tag_way);
		check_sel("reset way_sel", '0, way_sel);
		check_red("reset repair", '0, readback_word());

		// Fill every set and way
		for (int s = 0; s < `L2T_SETS; s++) begin
			for (int w = 0; w < `L2T_WAYS; w++) begin
				tag_cycle(1'b0, 1'b1, s, way_oh_t'(1 << w), $random(seed));
			end
		end

		// Mixed reads, writes and idle cycles
		for (int n = 0; n < N_RAND; n++) begin
			r = $random(seed);
			case (r[1:0])
				2'd0, 2'd1: tag_cycle(1'b1, 1'b0, r[9:4], r[13:10], $random(seed));
				2'd2: tag_cycle(1'b0, 1'b1, r[9:4], way_oh_t'(1 << r[3:2]), $random(seed));
				default: tag_cycle(1'b0, 1'b0, r[9:4], r[13:10], $random(seed));
			endcase
		end
		repeat (2) tag_cycle(1'b0, 1'b0, '0, '0, '0);	// Drain the last read

		for (int n = 0; n < N_FUSE; n++) begin
			fuse_cycle(red_rid_t'(n));
		end

		$display("ALL CHECKS PASSED");
		$finish;
	end

endmodule

`default_nettype wire

/* all.f */
+incdir+common
common/l2t_pkg.sv
common/l2t_red_pkg.sv
common/l2t_req_if.sv
hw/l2t_req_stage.sv
l2t_array/l2t_tag_array.sv
hw/l2t_way_cmp.sv
hw/l2t_red_regs.sv
hw/l2t_top.sv
verif/l2t_chk.sv
verif/l2t_tb.sv
